// File: logic/cfg_pkg.sv
// Layout is fixed at two 16-byte windows; value and mask travel byte-swapped on the wire

package cfg_pkg;

    // ----------------------------------------------------------------------
    // Register window layout
    // ----------------------------------------------------------------------

    localparam logic [15:0] STATUS_MAGIC       = 16'h2301;
    localparam logic [15:0] CONTROL_MAGIC      = 16'h6745;
    localparam int          WINDOW_BYTES       = 16;
    localparam int          WINDOW_BITS        = WINDOW_BYTES * 8;

    localparam int          CTL_BIT_RD_START   = 16;   // +002 bit 0
    localparam int          CTL_BIT_WR_START   = 17;
    localparam int          CTL_BIT_WAIT_DONE  = 18;   // Stall commands while access pending

    localparam int          POS_BYTECOUNT      = 32;   // +004 in both windows
    localparam int          CTL_POS_DI         = 64;   // +008
    localparam int          CTL_POS_DWADDR     = 96;   // +00C
    localparam int          CTL_POS_RDONLY     = 106;
    localparam int          CTL_POS_RW1C       = 107;
    localparam int          CTL_POS_BYTE_EN    = 108;

    localparam int          STS_POS_MGMT_EN    = 16;   // +002
    localparam int          STS_POS_RESULT     = 64;   // +008
    localparam int          STS_POS_DATA       = 96;   // +00C

    localparam logic [3:0]  MGMT_BYTE_EN_RESET = 4'hF;

    // ----------------------------------------------------------------------
    // Host command and reply words
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic [15:0] value;         // High byte sent last
        logic [15:0] mask;          // Same byte order as value
        logic        window_rw;     // 1 selects control window
        logic [14:0] byte_offset;
        logic [1:0]  op_rsvd;
        logic        op_write;
        logic        op_read;
        logic [11:0] rsvd;
    } cmd_word_t;

    typedef struct packed {
        logic [15:0] addr;          // Echo of window_rw and byte_offset
        logic [15:0] data;          // Byte-swapped
    } reply_t;

    // ----------------------------------------------------------------------
    // Configuration-management port of the PCIe core
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
        logic [3:0]  byte_en;
    } mgmt_req_t;

    typedef struct packed {
        logic        done;
        logic [31:0] do_data;
    } mgmt_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [9:0]  addr;
        logic [3:0]  byte_en;
        logic [31:0] data;
    } mgmt_result_t;

    typedef struct packed {
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
        logic [3:0]  byte_en;
    } mgmt_setup_t;

endpackage

// File: logic/cfg_cmd_engine.sv
// One command in flight; host must honor four-phase req/ack on both ports or words are lost

`timescale 1ns/1ns

module cfg_cmd_engine (
    input  logic               clk_pcie,
    input  logic               rst,
    input  logic               i_cmd_req,
    input  cfg_pkg::cmd_word_t i_cmd_word,
    output logic               o_cmd_ack,
    output logic               o_rsp_req,
    output cfg_pkg::reply_t    o_rsp_word,
    input  logic               i_rsp_ack,
    input  logic               i_hold,
    output logic               o_rd_window_rw,
    output logic [14:0]        o_rd_offset,
    input  logic [15:0]        i_rd_data,
    output logic               o_wr_strobe,
    output logic [14:0]        o_wr_offset,
    output logic [15:0]        o_wr_value,
    output logic [15:0]        o_wr_mask
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REPLY,       // Reply req high until the host acks
        ST_RELEASE,     // Reply req low until host ack falls
        ST_ACK          // Command ack high until host req falls
    } state_t;

    state_t state;
    logic   accept;
    logic   accept_rd;

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------

    assign accept    = (state == ST_IDLE) && i_cmd_req && !o_cmd_ack && !i_hold;
    assign accept_rd = accept && i_cmd_word.op_read;

    assign o_rd_window_rw = i_cmd_word.window_rw;   // Register file reads are combinational
    assign o_rd_offset    = i_cmd_word.byte_offset;

    assign o_wr_offset = i_cmd_word.byte_offset;
    assign o_wr_value  = {i_cmd_word.value[7:0], i_cmd_word.value[15:8]};  // Back to bit order
    assign o_wr_mask   = {i_cmd_word.mask[7:0], i_cmd_word.mask[15:8]};

    // Status window is read-only, so such writes are accepted and dropped
    assign o_wr_strobe = accept && i_cmd_word.op_write && i_cmd_word.window_rw;

    // ----------------------------------------------------------------------
    // Handshake FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            state     <= ST_IDLE;
            o_cmd_ack <= 1'b0;
            o_rsp_req <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (accept_rd)
                    begin
                        o_rsp_req <= 1'b1;          // Reply goes out before the ack
                        state     <= ST_REPLY;
                    end
                    else if (accept)
                    begin
                        o_cmd_ack <= 1'b1;
                        state     <= ST_ACK;
                    end
                end
                ST_REPLY:
                begin
                    if (i_rsp_ack)
                    begin
                        o_rsp_req <= 1'b0;
                        state     <= ST_RELEASE;
                    end
                end
                ST_RELEASE:
                begin
                    if (!i_rsp_ack)
                    begin
                        o_cmd_ack <= 1'b1;
                        state     <= ST_ACK;
                    end
                end
                ST_ACK:
                begin
                    if (!i_cmd_req)
                    begin
                        o_cmd_ack <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Reply payload is held stable while o_rsp_req is high
    always_ff @(posedge clk_pcie)
    begin
        if (accept_rd)
        begin
            o_rsp_word.addr <= {i_cmd_word.window_rw, i_cmd_word.byte_offset};
            o_rsp_word.data <= {i_rd_data[7:0], i_rd_data[15:8]};
        end
    end

endmodule

// File: logic/cfg_regfile.sv
// Control window writes are 16-bit masked; bits past byte 16 are dropped and read back as zero

`timescale 1ns/1ns

module cfg_regfile (
    input  logic                  clk_pcie,
    input  logic                  rst,
    input  logic                  i_rd_window_rw,
    input  logic [14:0]           i_rd_offset,
    output logic [15:0]           o_rd_data,
    input  logic                  i_wr_strobe,
    input  logic [14:0]           i_wr_offset,
    input  logic [15:0]           i_wr_value,
    input  logic [15:0]           i_wr_mask,
    input  logic                  i_take_rd,
    input  logic                  i_take_wr,
    input  logic                  i_busy,
    input  logic [1:0]            i_mgmt_en,
    input  cfg_pkg::mgmt_result_t i_result,
    output cfg_pkg::mgmt_setup_t  o_setup,
    output logic                  o_rd_start,
    output logic                  o_wr_start,
    output logic                  o_hold
);

    logic [cfg_pkg::WINDOW_BITS-1:0]  ctl;
    logic [cfg_pkg::WINDOW_BITS-1:0]  sts;
    logic [cfg_pkg::WINDOW_BITS+15:0] rd_window;    // Zero pad above the top byte
    logic [6:0]                       rd_bit;
    logic [17:0]                      wr_bit;
    logic [cfg_pkg::WINDOW_BITS-1:0]  wr_mask_wide;
    logic [cfg_pkg::WINDOW_BITS-1:0]  wr_value_wide;

    // ----------------------------------------------------------------------
    // Status window
    // ----------------------------------------------------------------------

    assign sts[15:0]                          = cfg_pkg::STATUS_MAGIC;    // +000
    assign sts[cfg_pkg::STS_POS_MGMT_EN +: 2] = i_mgmt_en;                // +002 rd, wr
    assign sts[31:18]                         = '0;
    assign sts[cfg_pkg::POS_BYTECOUNT +: 32]  = 32'(cfg_pkg::WINDOW_BYTES); // +004
    assign sts[cfg_pkg::STS_POS_RESULT +: 10] = i_result.addr;            // +008
    assign sts[74]                            = 1'b0;
    assign sts[75]                            = i_result.valid;
    assign sts[79:76]                         = i_result.byte_en;
    assign sts[95:80]                         = '0;
    assign sts[cfg_pkg::STS_POS_DATA +: 32]   = i_result.data;            // +00C

    // ----------------------------------------------------------------------
    // Reads
    // ----------------------------------------------------------------------

    assign rd_window = {16'h0000, i_rd_window_rw ? ctl : sts};
    assign rd_bit    = {i_rd_offset[3:0], 3'b000};
    assign o_rd_data = (i_rd_offset < 15'(cfg_pkg::WINDOW_BYTES)) ?
                       rd_window[rd_bit +: 16] : 16'h0000;

    // ----------------------------------------------------------------------
    // Control window
    // ----------------------------------------------------------------------

    assign wr_bit        = {i_wr_offset, 3'b000};
    assign wr_mask_wide  = {{(cfg_pkg::WINDOW_BITS-16){1'b0}}, i_wr_mask} << wr_bit;
    assign wr_value_wide = {{(cfg_pkg::WINDOW_BITS-16){1'b0}}, i_wr_value} << wr_bit;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            ctl                                  <= '0;
            ctl[15:0]                            <= cfg_pkg::CONTROL_MAGIC;
            ctl[cfg_pkg::POS_BYTECOUNT +: 32]    <= 32'(cfg_pkg::WINDOW_BYTES);
            ctl[cfg_pkg::CTL_POS_BYTE_EN +: 4]   <= cfg_pkg::MGMT_BYTE_EN_RESET;
        end
        else
        begin
            if (i_wr_strobe)
            begin
                ctl <= (ctl & ~wr_mask_wide) | (wr_value_wide & wr_mask_wide);
            end
            if (i_take_rd)
            begin
                ctl[cfg_pkg::CTL_BIT_RD_START] <= 1'b0;   // Sequencer has taken it
            end
            if (i_take_wr)
            begin
                ctl[cfg_pkg::CTL_BIT_WR_START] <= 1'b0;
            end
        end
    end

    assign o_setup.di            = ctl[cfg_pkg::CTL_POS_DI +: 32];
    assign o_setup.dwaddr        = ctl[cfg_pkg::CTL_POS_DWADDR +: 10];
    assign o_setup.wr_readonly   = ctl[cfg_pkg::CTL_POS_RDONLY];
    assign o_setup.wr_rw1c_as_rw = ctl[cfg_pkg::CTL_POS_RW1C];
    assign o_setup.byte_en       = ctl[cfg_pkg::CTL_POS_BYTE_EN +: 4];

    assign o_rd_start = ctl[cfg_pkg::CTL_BIT_RD_START];
    assign o_wr_start = ctl[cfg_pkg::CTL_BIT_WR_START];

    // Covers the gap between a start bit landing and the sequencer going busy
    assign o_hold = ctl[cfg_pkg::CTL_BIT_WAIT_DONE] & (o_rd_start | o_wr_start | i_busy);

endmodule

// File: logic/cfg_mgmt_seq.sv
// One access at a time; setup fields are sampled live, so change them only while idle

`timescale 1ns/1ns

module cfg_mgmt_seq (
    input  logic                  clk_pcie,
    input  logic                  rst,
    input  cfg_pkg::mgmt_setup_t  i_setup,
    input  logic                  i_rd_start,
    input  logic                  i_wr_start,
    output logic                  o_take_rd,
    output logic                  o_take_wr,
    output logic                  o_busy,
    output logic [1:0]            o_mgmt_en,
    output cfg_pkg::mgmt_result_t o_result,
    output cfg_pkg::mgmt_req_t    o_mgmt_req,
    input  cfg_pkg::mgmt_rsp_t    i_mgmt_rsp
);

    logic rd_pend;
    logic wr_pend;

    assign o_busy    = rd_pend | wr_pend;
    assign o_take_rd = ~o_busy & i_rd_start;                 // Read wins over write
    assign o_take_wr = ~o_busy & ~i_rd_start & i_wr_start;

    // ----------------------------------------------------------------------
    // Core request is dropped in the done cycle
    // ----------------------------------------------------------------------

    assign o_mgmt_req.rd_en         = rd_pend & ~i_mgmt_rsp.done;
    assign o_mgmt_req.wr_en         = wr_pend & ~i_mgmt_rsp.done;
    assign o_mgmt_req.di            = i_setup.di;
    assign o_mgmt_req.dwaddr        = i_setup.dwaddr;
    assign o_mgmt_req.wr_readonly   = i_setup.wr_readonly;
    assign o_mgmt_req.wr_rw1c_as_rw = i_setup.wr_rw1c_as_rw;
    assign o_mgmt_req.byte_en       = i_setup.byte_en;

    assign o_mgmt_en = {o_mgmt_req.wr_en, o_mgmt_req.rd_en};

    // ----------------------------------------------------------------------
    // Access sequencing and result capture
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rd_pend  <= 1'b0;
            wr_pend  <= 1'b0;
            o_result <= '{valid: 1'b0, addr: '0,
                          byte_en: cfg_pkg::MGMT_BYTE_EN_RESET, data: '0};
        end
        else if (o_busy && i_mgmt_rsp.done)
        begin
            rd_pend          <= 1'b0;
            wr_pend          <= 1'b0;
            o_result.valid   <= 1'b1;
            o_result.addr    <= i_setup.dwaddr;
            o_result.byte_en <= i_setup.byte_en;
            o_result.data    <= i_mgmt_rsp.do_data;
        end
        else if (o_take_rd)
        begin
            rd_pend        <= 1'b1;
            o_result.valid <= 1'b0;
        end
        else if (o_take_wr)
        begin
            wr_pend        <= 1'b1;
            o_result.valid <= 1'b0;
        end
    end

endmodule

// File: logic/pcie_cfg_top.sv
// Single clk_pcie domain; the PCIe core must hold done for exactly one cycle per access

`timescale 1ns/1ns

module pcie_cfg_top (
    input  logic               clk_pcie,
    input  logic               rst,
    input  logic               i_cmd_req,
    input  cfg_pkg::cmd_word_t i_cmd_word,
    output logic               o_cmd_ack,
    output logic               o_rsp_req,
    output cfg_pkg::reply_t    o_rsp_word,
    input  logic               i_rsp_ack,
    output cfg_pkg::mgmt_req_t o_mgmt_req,
    input  cfg_pkg::mgmt_rsp_t i_mgmt_rsp
);

    logic                  hold;
    logic                  rd_window_rw;
    logic [14:0]           rd_offset;
    logic [15:0]           rd_data;
    logic                  wr_strobe;
    logic [14:0]           wr_offset;
    logic [15:0]           wr_value;
    logic [15:0]           wr_mask;
    logic                  take_rd;
    logic                  take_wr;
    logic                  busy;
    logic [1:0]            mgmt_en;
    logic                  rd_start;
    logic                  wr_start;
    cfg_pkg::mgmt_result_t result;
    cfg_pkg::mgmt_setup_t  setup;

    cfg_cmd_engine i_cfg_cmd_engine (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .i_cmd_req      (i_cmd_req),
        .i_cmd_word     (i_cmd_word),
        .o_cmd_ack      (o_cmd_ack),
        .o_rsp_req      (o_rsp_req),
        .o_rsp_word     (o_rsp_word),
        .i_rsp_ack      (i_rsp_ack),
        .i_hold         (hold),
        .o_rd_window_rw (rd_window_rw),
        .o_rd_offset    (rd_offset),
        .i_rd_data      (rd_data),
        .o_wr_strobe    (wr_strobe),
        .o_wr_offset    (wr_offset),
        .o_wr_value     (wr_value),
        .o_wr_mask      (wr_mask)
    );

    cfg_regfile i_cfg_regfile (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .i_rd_window_rw (rd_window_rw),
        .i_rd_offset    (rd_offset),
        .o_rd_data      (rd_data),
        .i_wr_strobe    (wr_strobe),
        .i_wr_offset    (wr_offset),
        .i_wr_value     (wr_value),
        .i_wr_mask      (wr_mask),
        .i_take_rd      (take_rd),
        .i_take_wr      (take_wr),
        .i_busy         (busy),
        .i_mgmt_en      (mgmt_en),
        .i_result       (result),
        .o_setup        (setup),
        .o_rd_start     (rd_start),
        .o_wr_start     (wr_start),
        .o_hold         (hold)
    );

    cfg_mgmt_seq i_cfg_mgmt_seq (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .i_setup        (setup),
        .i_rd_start     (rd_start),
        .i_wr_start     (wr_start),
        .o_take_rd      (take_rd),
        .o_take_wr      (take_wr),
        .o_busy         (busy),
        .o_mgmt_en      (mgmt_en),
        .o_result       (result),
        .o_mgmt_req     (o_mgmt_req),
        .i_mgmt_rsp     (i_mgmt_rsp)
    );

endmodule

// File: tests/cfg_space_model.sv
// Answers each access after i_latency cycles (1 to 8) and keeps only the last write request

`timescale 1ns/1ns

module cfg_space_model (
    input  logic               clk_pcie,
    input  logic               rst,
    input  logic [3:0]         i_latency,
    input  cfg_pkg::mgmt_req_t i_mgmt_req,
    output cfg_pkg::mgmt_rsp_t o_mgmt_rsp,
    output cfg_pkg::mgmt_req_t o_last_write,
    output logic [7:0]         o_write_count
);

    logic [3:0] wait_cnt;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            wait_cnt      <= '0;
            o_mgmt_rsp    <= '0;
            o_last_write  <= '0;
            o_write_count <= '0;
        end
        else
        begin
            o_mgmt_rsp.done <= 1'b0;                        // Single-cycle pulse
            if (i_mgmt_req.rd_en || i_mgmt_req.wr_en)
            begin
                if (wait_cnt + 4'd1 >= i_latency)
                begin
                    wait_cnt        <= '0;
                    o_mgmt_rsp.done <= 1'b1;
                    if (i_mgmt_req.rd_en)
                    begin
                        o_mgmt_rsp.do_data <= {22'h0, i_mgmt_req.dwaddr} ^ 32'hA5A5_0000;
                    end
                    if (i_mgmt_req.wr_en)
                    begin
                        o_last_write  <= i_mgmt_req;
                        o_write_count <= o_write_count + 8'd1;
                    end
                end
                else
                begin
                    wait_cnt <= wait_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// File: tests/tb_pcie_cfg.sv
// Needs cfg_space_model; the run is cut off after MAX_CYCLES clock cycles

`timescale 1ns/1ns

module tb_pcie_cfg;

    // Six tests of about 40 commands of at most 15 cycles each
    localparam int MAX_CYCLES = 4000;

    logic               clk_pcie;
    logic               rst;
    logic               i_cmd_req;
    cfg_pkg::cmd_word_t i_cmd_word;
    logic               o_cmd_ack;
    logic               o_rsp_req;
    cfg_pkg::reply_t    o_rsp_word;
    logic               i_rsp_ack;
    cfg_pkg::mgmt_req_t mgmt_req;
    cfg_pkg::mgmt_rsp_t mgmt_rsp;
    cfg_pkg::mgmt_req_t last_write;
    logic [7:0]         write_count;
    logic [3:0]         model_latency;
    logic               wait_check;
    logic [31:0]        rand_state;
    int                 cycle_count;
    int                 check_count;
    int                 error_count;
    int                 rd_en_fails;
    int                 reply_fails;
    int                 hold_fails;
    int                 checks_mark;
    int                 errors_mark;

    pcie_cfg_top i_pcie_cfg_top (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .i_cmd_req  (i_cmd_req),
        .i_cmd_word (i_cmd_word),
        .o_cmd_ack  (o_cmd_ack),
        .o_rsp_req  (o_rsp_req),
        .o_rsp_word (o_rsp_word),
        .i_rsp_ack  (i_rsp_ack),
        .o_mgmt_req (mgmt_req),
        .i_mgmt_rsp (mgmt_rsp)
    );

    cfg_space_model i_cfg_space_model (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .i_latency     (model_latency),
        .i_mgmt_req    (mgmt_req),
        .o_mgmt_rsp    (mgmt_rsp),
        .o_last_write  (last_write),
        .o_write_count (write_count)
    );

    initial
    begin
        clk_pcie = 1'b0;
        forever #10 clk_pcie = ~clk_pcie;
    end

    always @(posedge clk_pcie)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Protocol properties
    // ----------------------------------------------------------------------

    assert property (@(posedge clk_pcie) disable iff (rst) mgmt_rsp.done |=> !mgmt_req.rd_en)
    else
    begin
        rd_en_fails++;
        $display("rd_en was high in the cycle after done at %0t", $time);
    end

    assert property (@(posedge clk_pcie) disable iff (rst)
        (o_rsp_req && !i_rsp_ack) |=> $stable(o_rsp_word))
    else
    begin
        reply_fails++;
        $display("Reply word changed while waiting for its ack at %0t", $time);
    end

    assert property (@(posedge clk_pcie) disable iff (rst)
        (wait_check && $rose(o_cmd_ack)) |-> !mgmt_req.rd_en)
    else
    begin
        hold_fails++;
        $display("Command ack rose during a pending read with wait-done at %0t", $time);
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] swap_bytes(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    function automatic int total_errors();
        return error_count + rd_en_fails + reply_fails + hold_fails;
    endfunction

    function automatic cfg_pkg::cmd_word_t build_cmd(input logic win, input logic [14:0] off,
            input logic [15:0] value, input logic [15:0] mask, input logic wr, input logic rd);
        cfg_pkg::cmd_word_t cmd;
        cmd             = '0;
        cmd.value       = swap_bytes(value);              // High byte travels last
        cmd.mask        = swap_bytes(mask);
        cmd.window_rw   = win;
        cmd.byte_offset = off;
        cmd.op_write    = wr;
        cmd.op_read     = rd;
        return cmd;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            error_count++;
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic release_cmd();
        do @(posedge clk_pcie); while (!o_cmd_ack);
        i_cmd_req <= 1'b0;
        do @(posedge clk_pcie); while (o_cmd_ack);
    endtask

    task automatic do_write(input logic win, input logic [14:0] off, input logic [15:0] value,
            input logic [15:0] mask);
        i_cmd_word <= build_cmd(win, off, value, mask, 1'b1, 1'b0);
        i_cmd_req  <= 1'b1;
        release_cmd();
    endtask

    task automatic do_read(input logic win, input logic [14:0] off, output cfg_pkg::reply_t rsp);
        i_cmd_word <= build_cmd(win, off, 16'h0000, 16'h0000, 1'b0, 1'b1);
        i_cmd_req  <= 1'b1;
        do @(posedge clk_pcie); while (!o_rsp_req);
        rsp        = o_rsp_word;
        rand_state = xorshift32(rand_state);
        repeat (int'(rand_state[1:0])) @(posedge clk_pcie);   // Random back-pressure
        i_rsp_ack <= 1'b1;
        do @(posedge clk_pcie); while (o_rsp_req);
        i_rsp_ack <= 1'b0;
        release_cmd();
        check_value("o_rsp_word.addr", 32'(rsp.addr), 32'({win, off}));
    endtask

    task automatic check_read(input logic win, input logic [14:0] off, input logic [15:0] exp);
        cfg_pkg::reply_t rsp;
        do_read(win, off, rsp);
        check_value("o_rsp_word.data", 32'(rsp.data), 32'(swap_bytes(exp)));
    endtask

    task automatic wait_valid(output logic [15:0] word);
        cfg_pkg::reply_t rsp;
        do
        begin
            do_read(1'b0, 15'h008, rsp);
            word = swap_bytes(rsp.data);
        end
        while (!word[11]);                                 // Result valid flag
    endtask

    task automatic end_test(input string name);
        $display("%-18s %0d checks, %0d errors", name, check_count - checks_mark,
                 total_errors() - errors_mark);
        checks_mark = check_count;
        errors_mark = total_errors();
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    initial
    begin
        cfg_pkg::reply_t rsp_lo;
        cfg_pkg::reply_t rsp_hi;
        logic [15:0]     word;
        logic [15:0]     shadow;
        logic [15:0]     value;
        logic [15:0]     mask;
        logic [9:0]      dwaddr;
        logic [3:0]      byte_en;
        logic [31:0]     di;
        logic [7:0]      writes_before;
        rst           = 1'b1;
        i_cmd_req     = 1'b0;
        i_cmd_word    = '0;
        i_rsp_ack     = 1'b0;
        model_latency = 4'd1;
        wait_check    = 1'b0;
        rand_state    = 32'd33213;
        cycle_count   = 0;
        check_count   = 0;
        error_count   = 0;
        rd_en_fails   = 0;
        reply_fails   = 0;
        hold_fails    = 0;
        checks_mark   = 0;
        errors_mark   = 0;
        repeat (4) @(posedge clk_pcie);
        rst <= 1'b0;

        check_value("o_mgmt_req.rd_en", 32'(mgmt_req.rd_en), 32'h0);
        check_value("o_mgmt_req.wr_en", 32'(mgmt_req.wr_en), 32'h0);
        check_read(1'b0, 15'h000, 16'h2301);
        check_read(1'b0, 15'h002, 16'h0000);               // Request enables low
        check_read(1'b0, 15'h004, 16'h0010);
        check_read(1'b0, 15'h006, 16'h0000);
        check_read(1'b0, 15'h008, 16'hF000);               // Byte enables set and valid low
        check_read(1'b1, 15'h000, 16'h6745);
        check_read(1'b1, 15'h002, 16'h0000);
        check_read(1'b1, 15'h004, 16'h0010);
        check_read(1'b1, 15'h00C, 16'hF000);
        end_test("reset values");

        shadow = 16'h0000;
        repeat (16)
        begin
            rand_state = xorshift32(rand_state);
            value      = rand_state[15:0];
            mask       = rand_state[31:16];
            shadow     = (shadow & ~mask) | (value & mask);
            do_write(1'b1, 15'h008, value, mask);
            check_read(1'b1, 15'h008, shadow);
        end
        end_test("masked writes");

        check_read(1'b0, 15'h010, 16'h0000);
        check_read(1'b1, 15'h014, 16'h0000);
        check_read(1'b1, 15'h7FFF, 16'h0000);
        do_write(1'b0, 15'h008, 16'hFFFF, 16'hFFFF);       // Read-only window
        do_write(1'b1, 15'h010, 16'hFFFF, 16'hFFFF);       // Past the window
        check_read(1'b1, 15'h008, shadow);
        check_read(1'b1, 15'h000, 16'h6745);
        check_read(1'b0, 15'h000, 16'h2301);
        check_read(1'b0, 15'h008, 16'hF000);
        end_test("ignored accesses");

        repeat (3)
        begin
            rand_state    = xorshift32(rand_state);
            dwaddr        = rand_state[9:0];
            byte_en       = rand_state[15:12];
            model_latency <= {1'b0, rand_state[18:16]} + 4'd1;
            do_write(1'b1, 15'h00C, {byte_en, 2'b00, dwaddr}, 16'hFFFF);
            do_write(1'b1, 15'h002, 16'h0001, 16'h0001);   // Read start
            wait_valid(word);
            check_value("result addr", 32'(word[9:0]), 32'(dwaddr));
            check_value("result byte_en", 32'(word[15:12]), 32'(byte_en));
            do_read(1'b0, 15'h00C, rsp_lo);
            do_read(1'b0, 15'h00E, rsp_hi);
            check_value("result data", {swap_bytes(rsp_hi.data), swap_bytes(rsp_lo.data)},
                        {22'h0, dwaddr} ^ 32'hA5A5_0000);
        end
        end_test("config read");

        rand_state    = xorshift32(rand_state);
        di            = rand_state;
        rand_state    = xorshift32(rand_state);
        dwaddr        = rand_state[9:0];
        byte_en       = rand_state[15:12];
        model_latency <= {1'b0, rand_state[18:16]} + 4'd1;
        writes_before = write_count;
        do_write(1'b1, 15'h008, di[15:0], 16'hFFFF);
        do_write(1'b1, 15'h00A, di[31:16], 16'hFFFF);
        do_write(1'b1, 15'h00C, {byte_en, 2'b10, dwaddr}, 16'hFFFF);   // rw1c as rw
        do_write(1'b1, 15'h002, 16'h0002, 16'h0002);       // Write start
        wait_valid(word);
        check_value("write count", 32'(write_count), 32'(writes_before + 8'd1));
        check_value("o_mgmt_req.di", last_write.di, di);
        check_value("o_mgmt_req.dwaddr", 32'(last_write.dwaddr), 32'(dwaddr));
        check_value("o_mgmt_req.byte_en", 32'(last_write.byte_en), 32'(byte_en));
        check_value("o_mgmt_req.wr_rw1c_as_rw", 32'(last_write.wr_rw1c_as_rw), 32'h1);
        check_value("o_mgmt_req.wr_readonly", 32'(last_write.wr_readonly), 32'h0);
        end_test("config write");

        model_latency <= 4'd8;
        wait_check = 1'b1;
        do_write(1'b1, 15'h002, 16'h0005, 16'h0007);       // Wait-done with read start
        do_read(1'b0, 15'h008, rsp_lo);                    // Held until done
        check_value("result valid", 32'(swap_bytes(rsp_lo.data) >> 11) & 32'h1, 32'h1);
        check_read(1'b0, 15'h002, 16'h0000);
        wait_check = 1'b0;
        do_write(1'b1, 15'h002, 16'h0000, 16'h0004);
        end_test("wait-done");

        $display("checks: %0d, failed checks: %0d, property failures: %0d", check_count,
                 error_count, rd_en_fails + reply_fails + hold_fails);
        if (total_errors() == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
logic/cfg_pkg.sv
logic/cfg_cmd_engine.sv
logic/cfg_regfile.sv
logic/cfg_mgmt_seq.sv
logic/pcie_cfg_top.sv
tests/cfg_space_model.sv
tests/tb_pcie_cfg.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_pcie_cfg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_pcie_cfg)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
